//--- source/freq_meter_pkg.sv
// frequency meter datapath widths and display limits
package freq_meter_pkg;

   // ======================================
   // period measurement
   // ======================================
   // unit counter width, saturates at 1023 units
   localparam int prd_width = 10;

   // ======================================
   // reciprocal division
   // ======================================
   // dividend and quotient share one width
   localparam int quo_width = 20;

   // ======================================
   // display conversion
   // ======================================
   // four decimal digits on the display
   localparam int bcd_digits = 4;

   // largest value the display can show
   localparam int bcd_max = 9999;

   // bits shifted by the converter, enough for bcd_max
   localparam int bin_width = 14;

endpackage

//--- source/freq_ctrl_pkg.sv
// state encodings for the frequency meter sequencer and its stages
package freq_ctrl_pkg;

   // master sequencer, one state per pipeline stage
   typedef enum logic [1:0] {
      seq_idle    = 2'b00,
      seq_measure = 2'b01,
      seq_divide  = 2'b10,
      seq_convert = 2'b11
   } seq_state_t;

   // shared by divider and converter
   typedef enum logic [1:0] {
      iter_idle = 2'b00,
      iter_op   = 2'b01,
      iter_done = 2'b10
   } iter_state_t;

   // period stage
   typedef enum logic [1:0] {
      meas_idle      = 2'b00,
      meas_wait_edge = 2'b01,
      meas_count     = 2'b10
   } meas_state_t;

endpackage

//--- source/period_measure.sv
// period measurement stage, counts time units between two rising edges of si
`timescale 1ns/10ps

module period_measure
   import freq_meter_pkg::*;
   import freq_ctrl_pkg::*;
#(
   parameter int clk_per_unit = 50000
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  logic                 si,
   output logic                 done_tick,
   output logic [prd_width-1:0] prd
);

   localparam int presc_width = $clog2(clk_per_unit + 1);
   localparam logic [presc_width-1:0] presc_last = presc_width'(clk_per_unit - 1);
   localparam logic [prd_width-1:0] unit_max = '1;

   meas_state_t state_reg, state_next;
   logic [1:0] sync_reg;
   logic si_del_reg;
   logic edge_tick;
   logic [presc_width-1:0] presc_reg, presc_next;
   logic [prd_width-1:0] unit_reg, unit_next, unit_inc;
   logic [prd_width-1:0] prd_next;
   logic unit_tick;
   logic done_next;

   // ======================================
   // input synchronizer and edge detect
   // ======================================
   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         sync_reg   <= 2'b00;
         si_del_reg <= 1'b0;
         state_reg  <= meas_idle;
         done_tick  <= 1'b0;
      end
      else
      begin
         sync_reg   <= {sync_reg[0], si};
         si_del_reg <= sync_reg[1];
         state_reg  <= state_next;
         done_tick  <= done_next;
      end

   assign edge_tick = sync_reg[1] & ~si_del_reg;

   // counters are cleared by the first edge before use
   always_ff @(posedge clk)
   begin
      presc_reg <= presc_next;
      unit_reg  <= unit_next;
      prd       <= prd_next;
   end

   // one unit elapses as the prescaler wraps
   assign unit_tick = (presc_reg == presc_last);
   assign unit_inc  = (unit_reg == unit_max) ? unit_reg : unit_reg + 1'b1;

   // ======================================
   // measurement control
   // ======================================
   always_comb
   begin
      state_next = state_reg;
      presc_next = presc_reg;
      unit_next  = unit_reg;
      prd_next   = prd;
      done_next  = 1'b0;
      case (state_reg)
         meas_idle:
            if (start)
               state_next = meas_wait_edge;
         meas_wait_edge:
            if (edge_tick)
            begin
               presc_next = '0;
               unit_next  = '0;
               state_next = meas_count;
            end
         meas_count:
         begin
            presc_next = unit_tick ? '0 : presc_reg + 1'b1;
            if (unit_tick)
               unit_next = unit_inc;
            // closing edge, include a unit finishing in this cycle
            if (edge_tick)
            begin
               prd_next   = unit_tick ? unit_inc : unit_reg;
               done_next  = 1'b1;
               state_next = meas_idle;
            end
         end
         default:
            state_next = meas_idle;
      endcase
   end

endmodule

//--- source/reciprocal_divider.sv
// restoring divider, computes a fixed dividend over the measured period
`timescale 1ns/10ps

module reciprocal_divider
   import freq_meter_pkg::*;
   import freq_ctrl_pkg::*;
#(
   parameter int dividend_value = 1000000
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  logic [prd_width-1:0] dvsr,
   output logic                 done_tick,
   output logic [quo_width-1:0] quo
);

   localparam int cnt_width = $clog2(quo_width + 1);
   localparam logic [quo_width-1:0] dividend = quo_width'(dividend_value);

   iter_state_t state_reg, state_next;
   logic [cnt_width-1:0] n_reg, n_next;
   logic [prd_width-1:0] dvsr_reg, dvsr_next;
   logic [prd_width-1:0] rem_reg, rem_next;
   logic [quo_width-1:0] quo_next;
   logic [prd_width:0] rem_shift, rem_diff;
   logic q_bit;

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         state_reg <= iter_idle;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         n_reg     <= n_next;
      end

   always_ff @(posedge clk)
   begin
      dvsr_reg <= dvsr_next;
      rem_reg  <= rem_next;
      quo      <= quo_next;
   end

   // ======================================
   // one subtract-and-shift step
   // ======================================
   // dividend bits enter the remainder from the top of quo
   assign rem_shift = {rem_reg, quo[quo_width-1]};
   assign rem_diff  = rem_shift - {1'b0, dvsr_reg};
   // a zero divisor always passes, giving all ones
   assign q_bit     = (rem_shift >= {1'b0, dvsr_reg});

   always_comb
   begin
      state_next = state_reg;
      n_next     = n_reg;
      dvsr_next  = dvsr_reg;
      rem_next   = rem_reg;
      quo_next   = quo;
      case (state_reg)
         iter_idle:
            if (start)
            begin
               dvsr_next  = dvsr;
               rem_next   = '0;
               quo_next   = dividend;
               n_next     = cnt_width'(quo_width);
               state_next = iter_op;
            end
         iter_op:
         begin
            rem_next = q_bit ? rem_diff[prd_width-1:0] : rem_shift[prd_width-1:0];
            quo_next = {quo[quo_width-2:0], q_bit};
            n_next   = n_reg - 1'b1;
            if (n_reg == cnt_width'(1))
               state_next = iter_done;
         end
         iter_done:
            state_next = iter_idle;
         default:
            state_next = iter_idle;
      endcase
   end

   // quo_width + 1 cycles after start
   assign done_tick = (state_reg == iter_done);

endmodule

//--- source/bcd_saturating_converter.sv
// shift-and-add-3 binary to bcd converter that saturates at the display limit
`timescale 1ns/10ps

module bcd_saturating_converter
   import freq_meter_pkg::*;
   import freq_ctrl_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  logic [quo_width-1:0] bin,
   output logic                 done_tick,
   output logic                 overflow,
   output logic [3:0]           bcd3,
   output logic [3:0]           bcd2,
   output logic [3:0]           bcd1,
   output logic [3:0]           bcd0
);

   localparam int cnt_width = $clog2(bin_width + 1);
   localparam int bcd_width = 4 * bcd_digits;

   iter_state_t state_reg, state_next;
   logic [cnt_width-1:0] n_reg, n_next;
   logic [bin_width-1:0] bin_reg, bin_next;
   logic [bcd_width-1:0] bcd_reg, bcd_next, bcd_adj, bcd_shift;
   logic [bcd_width-1:0] digits_reg, digits_next;
   logic sat_reg, sat_next;
   logic overflow_next;

   always_ff @(posedge clk, posedge reset)
      if (reset)
      begin
         state_reg  <= iter_idle;
         n_reg      <= '0;
         digits_reg <= '0;
         overflow   <= 1'b0;
      end
      else
      begin
         state_reg  <= state_next;
         n_reg      <= n_next;
         digits_reg <= digits_next;
         overflow   <= overflow_next;
      end

   always_ff @(posedge clk)
   begin
      bin_reg <= bin_next;
      bcd_reg <= bcd_next;
      sat_reg <= sat_next;
   end

   // ======================================
   // add 3 to each digit above 4, then shift
   // ======================================
   always_comb
   begin
      for (int i = 0; i < bcd_digits; i++)
         bcd_adj[4*i +: 4] = (bcd_reg[4*i +: 4] > 4'd4) ?
                             bcd_reg[4*i +: 4] + 4'd3 : bcd_reg[4*i +: 4];
   end

   assign bcd_shift = {bcd_adj[bcd_width-2:0], bin_reg[bin_width-1]};

   always_comb
   begin
      state_next    = state_reg;
      n_next        = n_reg;
      bin_next      = bin_reg;
      bcd_next      = bcd_reg;
      sat_next      = sat_reg;
      digits_next   = digits_reg;
      overflow_next = overflow;
      case (state_reg)
         iter_idle:
            if (start)
            begin
               // out of range, show the limit instead
               sat_next   = (bin > quo_width'(bcd_max));
               bin_next   = sat_next ? bin_width'(bcd_max) : bin[bin_width-1:0];
               bcd_next   = '0;
               n_next     = cnt_width'(bin_width);
               state_next = iter_op;
            end
         iter_op:
         begin
            bcd_next = bcd_shift;
            bin_next = {bin_reg[bin_width-2:0], 1'b0};
            n_next   = n_reg - 1'b1;
            // last step, digits and flag change together
            if (n_reg == cnt_width'(1))
            begin
               digits_next   = bcd_shift;
               overflow_next = sat_reg;
               state_next    = iter_done;
            end
         end
         iter_done:
            state_next = iter_idle;
         default:
            state_next = iter_idle;
      endcase
   end

   assign done_tick = (state_reg == iter_done);

   assign bcd3 = digits_reg[15:12];
   assign bcd2 = digits_reg[11:8];
   assign bcd1 = digits_reg[7:4];
   assign bcd0 = digits_reg[3:0];

endmodule

//--- source/freq_meter_sequencer.sv
// master fsm that chains period measurement, division and bcd conversion
`timescale 1ns/10ps

module freq_meter_sequencer
   import freq_ctrl_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic start,
   input  logic prd_done_tick,
   input  logic div_done_tick,
   input  logic cvt_done_tick,
   output logic prd_start,
   output logic div_start,
   output logic cvt_start,
   output logic ready,
   output logic done_tick
);

   seq_state_t state_reg, state_next;

   always_ff @(posedge clk, posedge reset)
      if (reset)
         state_reg <= seq_idle;
      else
         state_reg <= state_next;

   // ======================================
   // next state and stage strobes
   // ======================================
   // each start leaves in the cycle of the previous done tick
   always_comb
   begin
      state_next = state_reg;
      prd_start  = 1'b0;
      div_start  = 1'b0;
      cvt_start  = 1'b0;
      done_tick  = 1'b0;
      case (state_reg)
         seq_idle:
            if (start)
            begin
               prd_start  = 1'b1;
               state_next = seq_measure;
            end
         seq_measure:
            if (prd_done_tick)
            begin
               div_start  = 1'b1;
               state_next = seq_divide;
            end
         seq_divide:
            if (div_done_tick)
            begin
               cvt_start  = 1'b1;
               state_next = seq_convert;
            end
         seq_convert:
            if (cvt_done_tick)
            begin
               done_tick  = 1'b1;
               state_next = seq_idle;
            end
         default:
            state_next = seq_idle;
      endcase
   end

   // new measurements only from idle
   assign ready = (state_reg == seq_idle);

endmodule

//--- source/freq_meter_top.sv
// low frequency reciprocal counter, period to frequency in four bcd digits
`timescale 1ns/10ps

module freq_meter_top
   import freq_meter_pkg::*;
#(
   parameter int clk_per_unit   = 50000,
   parameter int dividend_value = 1000000
)
(
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   input  logic       si,
   output logic       ready,
   output logic       done_tick,
   output logic       overflow,
   output logic [3:0] bcd3,
   output logic [3:0] bcd2,
   output logic [3:0] bcd1,
   output logic [3:0] bcd0
);

   logic prd_start, div_start, cvt_start;
   logic prd_done_tick, div_done_tick, cvt_done_tick;
   logic [prd_width-1:0] prd;
   logic [quo_width-1:0] quo;

   // ======================================
   // pipeline stages
   // ======================================
   period_measure #(.clk_per_unit(clk_per_unit)) prd_unit
      (.clk(clk), .reset(reset), .start(prd_start), .si(si),
       .done_tick(prd_done_tick), .prd(prd));

   reciprocal_divider #(.dividend_value(dividend_value)) div_unit
      (.clk(clk), .reset(reset), .start(div_start), .dvsr(prd),
       .done_tick(div_done_tick), .quo(quo));

   bcd_saturating_converter cvt_unit
      (.clk(clk), .reset(reset), .start(cvt_start), .bin(quo),
       .done_tick(cvt_done_tick), .overflow(overflow),
       .bcd3(bcd3), .bcd2(bcd2), .bcd1(bcd1), .bcd0(bcd0));

   // master fsm
   freq_meter_sequencer seq_unit
      (.clk(clk), .reset(reset), .start(start),
       .prd_done_tick(prd_done_tick), .div_done_tick(div_done_tick),
       .cvt_done_tick(cvt_done_tick), .prd_start(prd_start),
       .div_start(div_start), .cvt_start(cvt_start),
       .ready(ready), .done_tick(done_tick));

endmodule

//--- verification/freq_meter_sva.sv
// protocol checks on the frequency meter top level strobes and digits
`timescale 1ns/10ps

module freq_meter_sva
(
   input logic       clk,
   input logic       reset,
   input logic       start,
   input logic       ready,
   input logic       done_tick,
   input logic       overflow,
   input logic [3:0] bcd3,
   input logic [3:0] bcd2,
   input logic [3:0] bcd1,
   input logic [3:0] bcd0
);

   // read by the testbench monitor
   int violation_count = 0;

   // ======================================
   // strobes and ready level
   // ======================================
   done_single: assert property (@(posedge clk) disable iff (reset)
      done_tick |=> !done_tick)
      else
      begin
         violation_count++;
         $error("done_tick lasted more than one cycle");
      end

   // accepted start drops ready
   ready_drop: assert property (@(posedge clk) disable iff (reset)
      (start && ready) |=> !ready)
      else
      begin
         violation_count++;
         $error("ready stayed high after an accepted start");
      end

   // ready falls only on a start
   ready_hold: assert property (@(posedge clk) disable iff (reset)
      (ready && !start) |=> ready)
      else
      begin
         violation_count++;
         $error("ready fell without a start");
      end

   // ready only rises through done_tick
   ready_wait: assert property (@(posedge clk) disable iff (reset)
      (!ready && !done_tick) |=> !ready)
      else
      begin
         violation_count++;
         $error("ready rose before done_tick");
      end

   ready_back: assert property (@(posedge clk) disable iff (reset)
      done_tick |=> ready)
      else
      begin
         violation_count++;
         $error("ready not restored after done_tick");
      end

   // ======================================
   // display contents
   // ======================================
   digit_range: assert property (@(posedge clk) disable iff (reset)
      (bcd3 <= 4'd9) && (bcd2 <= 4'd9) && (bcd1 <= 4'd9) && (bcd0 <= 4'd9))
      else
      begin
         violation_count++;
         $error("a bcd digit is above 9");
      end

   ovf_limit: assert property (@(posedge clk) disable iff (reset)
      overflow |-> ({bcd3, bcd2, bcd1, bcd0} == 16'h9999))
      else
      begin
         violation_count++;
         $error("overflow set but digits do not read 9999");
      end

endmodule

bind freq_meter_top freq_meter_sva protocol_checks
   (.clk(clk), .reset(reset), .start(start), .ready(ready),
    .done_tick(done_tick), .overflow(overflow),
    .bcd3(bcd3), .bcd2(bcd2), .bcd1(bcd1), .bcd0(bcd0));

//--- verification/freq_meter_tb.sv
// testbench for the reciprocal frequency meter, fixed and random input periods
`timescale 1ns/10ps

module freq_meter_tb
   import freq_meter_pkg::*;
();

   localparam int clk_per_unit   = 10;
   localparam int dividend_value = 1000000;
   localparam int num_random     = 20;
   localparam int num_tests      = 7 + num_random;
   localparam int timeout_limit  = num_tests * (2 * 1023 * clk_per_unit + 100);

   logic clk = 1'b0;
   logic reset, start, si;
   logic ready, done_tick, overflow;
   logic [3:0] bcd3, bcd2, bcd1, bcd0;

   logic [15:0] exp_digits;
   logic exp_overflow;
   logic [15:0] lfsr = 16'd28;
   int checks_done = 0;
   int cycle_count = 0;

   freq_meter_top #(.clk_per_unit(clk_per_unit), .dividend_value(dividend_value)) uut
      (.clk(clk), .reset(reset), .start(start), .si(si), .ready(ready),
       .done_tick(done_tick), .overflow(overflow),
       .bcd3(bcd3), .bcd2(bcd2), .bcd1(bcd1), .bcd0(bcd0));

   always #50 clk = ~clk;

   // ========================================
   // failure reporting
   // ========================================
   task automatic report_mismatch(input string what);
      $display("FAILED at %0t ns: %s", $time, what);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TESTS FAILED");
      $fatal(1, "run aborted");
   endtask

   // ========================================
   // reference model and random source
   // ========================================
   // expected {overflow, four digits} for a period of p units
   function automatic logic [16:0] expected_result(input int p);
      int prd;
      int quo;
      int shown;
      logic ovf;
      prd = (p > (1 << prd_width) - 1) ? (1 << prd_width) - 1 : p;
      if (prd == 0)
         quo = (1 << quo_width) - 1;
      else
         quo = dividend_value / prd;
      ovf   = (quo > bcd_max);
      shown = ovf ? bcd_max : quo;
      return {ovf, 4'(shown / 1000), 4'((shown / 100) % 10),
              4'((shown / 10) % 10), 4'(shown % 10)};
   endfunction

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
   endfunction

   // one lfsr step per bit
   task automatic draw_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++)
      begin
         value = (value << 1) | lfsr[0];
         lfsr  = lfsr_next(lfsr);
      end
   endtask

   // ========================================
   // one measurement with a square wave on si
   // ========================================
   task automatic run_measurement(input int period_units, input bit extra_start);
      int full_cyc;
      int half_cyc;
      int close_cyc;
      int cyc;
      full_cyc  = period_units * clk_per_unit;
      half_cyc  = full_cyc / 2;
      close_cyc = full_cyc + half_cyc;
      {exp_overflow, exp_digits} = expected_result(period_units);
      assert (ready)
         else abort_run("DUT was not ready before a new measurement");
      start = 1'b1;
      si    = 1'b0;
      cyc   = 0;
      // si starts low so the first rising edge follows start
      do
      begin
         @(negedge clk);
         cyc++;
         start = 1'b0;
         // extra start lands while the divider runs
         if (extra_start && cyc == close_cyc + 10)
         begin
            assert (!ready)
               else abort_run("ready was high while a measurement was running");
            start = 1'b1;
         end
         // two rising edges only, si then stays high
         si = (cyc < close_cyc) ? ((cyc % full_cyc) >= half_cyc) : 1'b1;
      end
      while (!done_tick);
      start = 1'b0;
      si    = 1'b0;
      repeat (4) @(negedge clk);
   endtask

   // ========================================
   // comparison and run limits
   // ========================================
   always @(negedge clk)
      if (!reset && done_tick)
      begin
         assert ({bcd3, bcd2, bcd1, bcd0} == exp_digits && overflow == exp_overflow)
            else report_mismatch($sformatf("got %h ovf %b, expected %h ovf %b",
                                 {bcd3, bcd2, bcd1, bcd0}, overflow,
                                 exp_digits, exp_overflow));
         checks_done++;
      end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_limit)
         abort_run("timeout, the DUT did not finish the measurements in time");
   end

   always @(negedge clk)
      if (uut.protocol_checks.violation_count != 0)
         abort_run("a protocol assertion on the DUT failed");

   initial
   begin
      int p;
      reset = 1'b1;
      start = 1'b0;
      si    = 1'b0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // idle state after reset
      assert (ready && !overflow && {bcd3, bcd2, bcd1, bcd0} == 16'h0000)
         else report_mismatch("outputs after reset are not idle");

      run_measurement(1000, 1'b0);
      run_measurement(400, 1'b0);
      run_measurement(137, 1'b0);
      // too fast for four digits
      run_measurement(50, 1'b0);
      run_measurement(1, 1'b0);
      // unit counter saturates
      run_measurement(1024, 1'b0);
      run_measurement(1100, 1'b0);

      for (int i = 0; i < num_random; i++)
      begin
         draw_bits(11, p);
         run_measurement(1 + (p % 1100), (i % 2) == 1);
      end

      assert (checks_done == num_tests)
         else abort_run("fewer results than measurements were seen");
      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- build.f
source/freq_meter_pkg.sv
source/freq_ctrl_pkg.sv
source/period_measure.sv
source/reciprocal_divider.sv
source/bcd_saturating_converter.sv
source/freq_meter_sequencer.sv
source/freq_meter_top.sv
verification/freq_meter_sva.sv
verification/freq_meter_tb.sv
